// ==== Bender.yml ====
package:
  name: acl_spi

sources:
  - acl_pkg.sv
  - spi_bit_clock.sv
  - spi_shifter.sv
  - axis_capture.sv
  - spi_sequencer.sv
  - acl_spi_top.sv
  - target: simulation
    files:
      - acl_sensor_model.sv
      - tb_acl_spi_top.sv

// ==== acl_pkg.sv ====
package acl_pkg;

    localparam int BYTE_W           = 8;
    localparam int SCLK_DIV         = 4;        // iclk cycles per sclk period
    localparam int POWER_UP_CYCLES  = 24000;    // 6 ms at 4 MHz
    localparam int MEAS_WAIT_CYCLES = 160000;   // 40 ms until first valid sample
    localparam int READ_GAP_CYCLES  = 40000;    // 10 ms between bursts
    localparam int READ_DATA_BYTES  = 6;
    localparam int FIELD_LSB        = 7;        // Lowest axis bit kept
    localparam int FIELD_W          = 5;        // Sign bit plus four data bits

    // Derived sizes
    localparam int NUM_AXES       = READ_DATA_BYTES / 2;
    localparam int MSB_PART_W     = FIELD_LSB + FIELD_W - BYTE_W;  // Field bits found in MSB byte
    localparam int WRITE_BYTES    = 3;
    localparam int READ_HDR_BYTES = 2;          // Command and start address
    localparam int READ_BYTES     = READ_HDR_BYTES + READ_DATA_BYTES;
    localparam int WAIT_W         = $clog2(MEAS_WAIT_CYCLES);
    localparam int BYTE_CNT_W     = $clog2(READ_BYTES + 1);
    localparam int PHASE_W        = $clog2(SCLK_DIV);
    localparam int BIT_CNT_W      = $clog2(BYTE_W);
    localparam int INDEX_W        = $clog2(READ_DATA_BYTES);

    typedef logic [BYTE_W-1:0] spi_byte_t;

    // Sensor instruction set and registers
    localparam spi_byte_t CMD_WRITE     = 8'h0A;
    localparam spi_byte_t CMD_READ      = 8'h0B;
    localparam spi_byte_t REG_POWER_CTL = 8'h2D;
    localparam spi_byte_t MEAS_MODE     = 8'h02;
    localparam spi_byte_t REG_XDATA_L   = 8'h0E;  // Auto-increments through Z-MSB

    typedef enum logic [2:0] {
        POWER_UP,
        MODE_WRITE,
        MEAS_WAIT,
        READ_BURST,
        READ_GAP
    } seq_state_t;

    typedef struct packed {
        logic      start;   // Load data and begin clocking
        logic      last;    // Chip-select rises after this byte
        spi_byte_t data;
    } tx_req_t;

    typedef struct packed {
        logic               store;      // Finished byte is a data byte
        logic [INDEX_W-1:0] index;      // X-LSB, X-MSB, Y-LSB, Y-MSB, Z-LSB, Z-MSB
        logic               burst_end;
    } rx_ctrl_t;

    typedef struct packed {
        logic [FIELD_W-1:0] x;
        logic [FIELD_W-1:0] y;
        logic [FIELD_W-1:0] z;
    } acl_sample_t;

endpackage

// ==== acl_sensor_model.sv ====
module acl_sensor_model (
    input  logic                 iclk,
    input  logic                 rst_n,
    input  logic                 sclk,
    input  logic                 mosi,
    input  logic                 cs_n,
    output logic                 miso,
    output acl_pkg::acl_sample_t exp_sample,
    output int                   frames,
    output int                   errors
);
    timeunit 1ns;
    timeprecision 1ps;

    acl_pkg::spi_byte_t served [acl_pkg::READ_DATA_BYTES];  // Register bytes X-LSB to Z-MSB
    acl_pkg::spi_byte_t rx_bytes [$];                      // Bytes seen on mosi this frame
    acl_pkg::spi_byte_t rx_sr;
    acl_pkg::spi_byte_t next_byte;
    logic               cs_q;
    logic               sclk_q;
    int                 rise_cnt;
    int                 idle_cnt;                          // Cycles with cs_n high
    logic               frame_begin;
    logic               frame_end;
    logic               gap_ok;
    logic               frame_ok;

    // Data is only served once a read command has been decoded
    function automatic acl_pkg::spi_byte_t slot_byte(input int slot);
        if (rx_bytes.size() > 0 && rx_bytes[0] == acl_pkg::CMD_READ &&
            slot >= acl_pkg::READ_HDR_BYTES && slot < acl_pkg::READ_BYTES) begin
            return served[slot - acl_pkg::READ_HDR_BYTES];
        end
        return '0;
    endfunction

    // Bits 11 to 7 of the 16-bit axis value, LSB byte first
    function automatic logic [acl_pkg::FIELD_W-1:0] axis_field(input int axis);
        logic [15:0] value;
        value = {served[2*axis+1], served[2*axis]};
        return value[acl_pkg::FIELD_LSB +: acl_pkg::FIELD_W];
    endfunction

    function automatic logic frame_matches(input int frame_no);
        if (rise_cnt % acl_pkg::BYTE_W != 0) begin
            return 1'b0;                                  // Partial byte clocked
        end
        if (frame_no == 0) begin
            return rx_bytes.size() == acl_pkg::WRITE_BYTES && rx_bytes[0] == acl_pkg::CMD_WRITE &&
                   rx_bytes[1] == acl_pkg::REG_POWER_CTL && rx_bytes[2] == acl_pkg::MEAS_MODE;
        end
        return rx_bytes.size() == acl_pkg::READ_BYTES && rx_bytes[0] == acl_pkg::CMD_READ &&
               rx_bytes[1] == acl_pkg::REG_XDATA_L;
    endfunction

    function automatic int required_gap(input int frame_no);
        if (frame_no == 0) begin
            return acl_pkg::POWER_UP_CYCLES;
        end else if (frame_no == 1) begin
            return acl_pkg::MEAS_WAIT_CYCLES;
        end
        return acl_pkg::READ_GAP_CYCLES;
    endfunction

    initial begin
        miso   = 1'b0;
        errors = 0;
    end

    always @(posedge iclk or negedge rst_n) begin
        if (!rst_n) begin
            miso        <= 1'b0;
            cs_q        <= 1'b1;
            sclk_q      <= 1'b0;
            rise_cnt    <= 0;
            idle_cnt    <= 0;
            frames      <= 0;
            frame_begin <= 1'b0;
            frame_end   <= 1'b0;
            gap_ok      <= 1'b1;
            frame_ok    <= 1'b1;
            exp_sample  <= '0;
        end else begin
            cs_q        <= cs_n;
            sclk_q      <= sclk;
            frame_begin <= 1'b0;
            frame_end   <= 1'b0;
            if (cs_n) begin
                idle_cnt <= (cs_q ? idle_cnt : 0) + 1;    // Rise cycle counts as the first
            end
            if (cs_q && !cs_n) begin
                frame_begin <= 1'b1;
                gap_ok      <= (idle_cnt >= required_gap(frames));
                rise_cnt    <= 0;
                rx_bytes.delete();
                foreach (served[i]) begin
                    served[i] = acl_pkg::spi_byte_t'($urandom);
                end
                exp_sample <= {axis_field(0), axis_field(1), axis_field(2)};
                miso       <= 1'b0;                       // Header slot
            end else if (!cs_n) begin
                if (!sclk_q && sclk) begin
                    rx_sr    <= {rx_sr[acl_pkg::BYTE_W-2:0], mosi};
                    rise_cnt <= rise_cnt + 1;
                    if ((rise_cnt + 1) % acl_pkg::BYTE_W == 0) begin
                        rx_bytes.push_back({rx_sr[acl_pkg::BYTE_W-2:0], mosi});
                    end
                end
                if (sclk_q && !sclk) begin
                    next_byte = slot_byte(rise_cnt / acl_pkg::BYTE_W);
                    miso <= next_byte[acl_pkg::BYTE_W - 1 - (rise_cnt % acl_pkg::BYTE_W)];
                end
            end
            if (!cs_q && cs_n) begin
                frame_end <= 1'b1;
                frame_ok  <= frame_matches(frames);
                frames    <= frames + 1;
            end
        end
    end

    a_sclk_low_when_idle: assert property (@(posedge iclk) disable iff (!rst_n)
        cs_n |-> !sclk)
        else begin
            errors++;
            $display("ERR %0t: sclk high while cs_n is high", $time);
        end

    a_mosi_stable_high: assert property (@(posedge iclk) disable iff (!rst_n)
        $changed(mosi) |-> !sclk)
        else begin
            errors++;
            $display("ERR %0t: mosi changed while sclk high", $time);
        end

    a_frame_format: assert property (@(posedge iclk) disable iff (!rst_n)
        frame_end |-> frame_ok)
        else begin
            errors++;
            $display("ERR %0t: frame %0d has wrong bytes or length", $time, frames - 1);
        end

    a_frame_spacing: assert property (@(posedge iclk) disable iff (!rst_n)
        frame_begin |-> gap_ok)
        else begin
            errors++;
            $display("ERR %0t: frame %0d opened too early", $time, frames);
        end

endmodule

// ==== acl_spi_top.sv ====
module acl_spi_top (
    input  logic                 iclk,
    input  logic                 rst_n,
    input  logic                 miso,
    output logic                 sclk,
    output logic                 mosi,
    output logic                 cs_n,
    output acl_pkg::acl_sample_t acl_data,
    output logic                 sample_valid
);

    acl_pkg::tx_req_t   tx_req;
    acl_pkg::rx_ctrl_t  rx_ctrl;
    acl_pkg::spi_byte_t rx_byte;
    logic               sample_pulse;
    logic               shift_pulse;
    logic               byte_done;

    spi_sequencer u_seq (
        .iclk      (iclk),
        .rst_n     (rst_n),
        .byte_done (byte_done),
        .tx_req    (tx_req),
        .rx_ctrl   (rx_ctrl),
        .cs_n      (cs_n)
    );

    spi_bit_clock u_bit_clk (
        .iclk         (iclk),
        .rst_n        (rst_n),
        .tx_req       (tx_req),
        .sclk         (sclk),
        .sample_pulse (sample_pulse),
        .shift_pulse  (shift_pulse),
        .byte_done    (byte_done)
    );

    spi_shifter u_shifter (
        .iclk         (iclk),
        .rst_n        (rst_n),
        .tx_req       (tx_req),
        .shift_pulse  (shift_pulse),
        .sample_pulse (sample_pulse),
        .miso         (miso),
        .mosi         (mosi),
        .rx_byte      (rx_byte)
    );

    axis_capture u_capture (
        .iclk         (iclk),
        .rst_n        (rst_n),
        .rx_ctrl      (rx_ctrl),
        .byte_done    (byte_done),
        .rx_byte      (rx_byte),
        .acl_data     (acl_data),
        .sample_valid (sample_valid)
    );

endmodule

// ==== axis_capture.sv ====
module axis_capture (
    input  logic                  iclk,
    input  logic                  rst_n,
    input  acl_pkg::rx_ctrl_t     rx_ctrl,
    input  logic                  byte_done,
    input  acl_pkg::spi_byte_t    rx_byte,
    output acl_pkg::acl_sample_t  acl_data,
    output logic                  sample_valid
);

    logic [acl_pkg::NUM_AXES-1:0]   lsb_bit;                        // Bit 7 of each LSB byte
    logic [acl_pkg::MSB_PART_W-1:0] msb_part [acl_pkg::NUM_AXES];   // Low nibble of MSB bytes
    logic [acl_pkg::INDEX_W-2:0]    axis;
    logic                           wr_en;
    logic                           sample_en;

    assign axis      = rx_ctrl.index[acl_pkg::INDEX_W-1:1];
    assign wr_en     = byte_done && rx_ctrl.store;
    assign sample_en = wr_en && rx_ctrl.burst_end;

    always_ff @(posedge iclk) begin
        if (wr_en) begin
            if (rx_ctrl.index[0]) begin
                msb_part[axis] <= rx_byte[acl_pkg::MSB_PART_W-1:0];
            end else begin
                lsb_bit[axis] <= rx_byte[acl_pkg::FIELD_LSB];
            end
        end
    end

    always_ff @(posedge iclk or negedge rst_n) begin
        if (!rst_n) begin
            acl_data     <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= sample_en;
            if (sample_en) begin
                acl_data.x <= {msb_part[0], lsb_bit[0]};
                acl_data.y <= {msb_part[1], lsb_bit[1]};
                // Z-MSB is arriving this cycle, take it straight from the shifter
                acl_data.z <= {rx_byte[acl_pkg::MSB_PART_W-1:0], lsb_bit[2]};
            end
        end
    end

    a_store_on_byte_done: assert property (@(posedge iclk) disable iff (!rst_n)
        rx_ctrl.store |-> byte_done)
        else $error("data store outside a byte_done cycle");

endmodule

// ==== filelist.f ====
acl_pkg.sv
spi_bit_clock.sv
spi_shifter.sv
axis_capture.sv
spi_sequencer.sv
acl_spi_top.sv
acl_sensor_model.sv
tb_acl_spi_top.sv

// ==== spi_bit_clock.sv ====
module spi_bit_clock (
    input  logic             iclk,
    input  logic             rst_n,
    input  acl_pkg::tx_req_t tx_req,
    output logic             sclk,
    output logic             sample_pulse,
    output logic             shift_pulse,
    output logic             byte_done
);

    logic                          active;
    logic [acl_pkg::PHASE_W-1:0]   phase;       // Cycle within the current bit
    logic [acl_pkg::PHASE_W-1:0]   phase_nxt;
    logic [acl_pkg::BIT_CNT_W-1:0] bit_cnt;     // 0 is bit 7 on the wire
    logic                          last_bit;

    assign phase_nxt = phase + 1'b1;
    assign last_bit  = (bit_cnt == acl_pkg::BIT_CNT_W'(acl_pkg::BYTE_W - 1));

    // Strobes line up with the registered sclk
    assign sample_pulse = active && (phase == acl_pkg::PHASE_W'(acl_pkg::SCLK_DIV / 2));
    assign shift_pulse  = active && (phase == acl_pkg::PHASE_W'(acl_pkg::SCLK_DIV - 1)) &&
                          !last_bit;

    always_ff @(posedge iclk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            phase     <= '0;
            bit_cnt   <= '0;
            sclk      <= 1'b0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (tx_req.start) begin
                active  <= 1'b1;
                phase   <= acl_pkg::PHASE_W'(1);      // Start cycle is phase 0 of bit 7
                bit_cnt <= '0;
                sclk    <= 1'b0;
            end else if (active) begin
                phase <= phase_nxt;
                sclk  <= (phase_nxt >= acl_pkg::PHASE_W'(acl_pkg::SCLK_DIV / 2));  // Low then high
                if (phase == acl_pkg::PHASE_W'(acl_pkg::SCLK_DIV - 1)) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit) begin
                        active    <= 1'b0;
                        byte_done <= 1'b1;
                    end
                end
            end else begin
                sclk <= 1'b0;
            end
        end
    end

    a_sclk_idle_low: assert property (@(posedge iclk) disable iff (!rst_n)
        !active |-> !sclk)
        else $error("sclk high while bit clock idle");

endmodule

// ==== spi_sequencer.sv ====
module spi_sequencer (
    input  logic              iclk,
    input  logic              rst_n,
    input  logic              byte_done,
    output acl_pkg::tx_req_t  tx_req,
    output acl_pkg::rx_ctrl_t rx_ctrl,
    output logic              cs_n
);

    acl_pkg::seq_state_t                state;
    logic [acl_pkg::WAIT_W-1:0]         wait_cnt;
    logic [acl_pkg::WAIT_W-1:0]         wait_limit;
    logic [acl_pkg::BYTE_CNT_W-1:0]     byte_cnt;     // Bytes started in this transaction
    logic [acl_pkg::BYTE_CNT_W-1:0]     xfer_len;
    logic [acl_pkg::BYTE_CNT_W-1:0]     data_idx;
    logic                               in_xfer;
    logic                               last_sent;    // Byte on the wire is the final one
    logic                               xfer_end;

    assign in_xfer  = (state == acl_pkg::MODE_WRITE) || (state == acl_pkg::READ_BURST);
    assign xfer_len = (state == acl_pkg::MODE_WRITE) ? acl_pkg::BYTE_CNT_W'(acl_pkg::WRITE_BYTES)
                                                     : acl_pkg::BYTE_CNT_W'(acl_pkg::READ_BYTES);
    assign xfer_end = in_xfer && byte_done && last_sent;

    // Chip-select is low from the first start until the final byte_done
    assign cs_n = !in_xfer || xfer_end;

    always_comb begin
        case (state)
            acl_pkg::POWER_UP:  wait_limit = acl_pkg::WAIT_W'(acl_pkg::POWER_UP_CYCLES - 1);
            acl_pkg::MEAS_WAIT: wait_limit = acl_pkg::WAIT_W'(acl_pkg::MEAS_WAIT_CYCLES - 1);
            default:            wait_limit = acl_pkg::WAIT_W'(acl_pkg::READ_GAP_CYCLES - 1);
        endcase
    end

    // Next byte goes out right in the byte_done cycle, so bytes run back to back
    always_comb begin
        tx_req = '0;
        if (in_xfer && (byte_cnt != xfer_len) && ((byte_cnt == '0) || byte_done)) begin
            tx_req.start = 1'b1;
            tx_req.last  = (byte_cnt == xfer_len - 1'b1);
            if (state == acl_pkg::MODE_WRITE) begin
                case (byte_cnt)
                    acl_pkg::BYTE_CNT_W'(0): tx_req.data = acl_pkg::CMD_WRITE;
                    acl_pkg::BYTE_CNT_W'(1): tx_req.data = acl_pkg::REG_POWER_CTL;
                    default:                 tx_req.data = acl_pkg::MEAS_MODE;
                endcase
            end else begin
                case (byte_cnt)
                    acl_pkg::BYTE_CNT_W'(0): tx_req.data = acl_pkg::CMD_READ;
                    acl_pkg::BYTE_CNT_W'(1): tx_req.data = acl_pkg::REG_XDATA_L;
                    default:                 tx_req.data = '0;  // Dummy bytes while reading
                endcase
            end
        end
    end

    // The byte just finished is number byte_cnt-1; data starts after the header
    assign data_idx = byte_cnt - acl_pkg::BYTE_CNT_W'(acl_pkg::READ_HDR_BYTES + 1);

    always_comb begin
        rx_ctrl.store = (state == acl_pkg::READ_BURST) && byte_done &&
                        (byte_cnt > acl_pkg::BYTE_CNT_W'(acl_pkg::READ_HDR_BYTES));
        rx_ctrl.index     = data_idx[acl_pkg::INDEX_W-1:0];
        rx_ctrl.burst_end = rx_ctrl.store &&
                            (byte_cnt == acl_pkg::BYTE_CNT_W'(acl_pkg::READ_BYTES));
    end

    always_ff @(posedge iclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= acl_pkg::POWER_UP;
            wait_cnt  <= '0;
            byte_cnt  <= '0;
            last_sent <= 1'b0;
        end else begin
            if (tx_req.start) begin
                byte_cnt  <= byte_cnt + 1'b1;
                last_sent <= tx_req.last;
            end
            if (in_xfer) begin
                if (xfer_end) begin
                    byte_cnt  <= '0;
                    last_sent <= 1'b0;
                    wait_cnt  <= acl_pkg::WAIT_W'(1);     // cs_n rise counts as cycle 0
                    state     <= (state == acl_pkg::MODE_WRITE) ? acl_pkg::MEAS_WAIT
                                                                : acl_pkg::READ_GAP;
                end
            end else if (wait_cnt == wait_limit) begin
                state <= (state == acl_pkg::POWER_UP) ? acl_pkg::MODE_WRITE
                                                      : acl_pkg::READ_BURST;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // Each wait also leaves the byte count cleared for the next transaction
    a_cs_idle_in_waits: assert property (@(posedge iclk) disable iff (!rst_n)
        (state inside {acl_pkg::POWER_UP, acl_pkg::MEAS_WAIT, acl_pkg::READ_GAP}) |->
        (cs_n && (byte_cnt == '0)))
        else $error("cs_n low or byte count not cleared outside a transaction");

endmodule

// ==== spi_shifter.sv ====
module spi_shifter (
    input  logic               iclk,
    input  logic               rst_n,
    input  acl_pkg::tx_req_t   tx_req,
    input  logic               shift_pulse,
    input  logic               sample_pulse,
    input  logic               miso,
    output logic               mosi,
    output acl_pkg::spi_byte_t rx_byte
);

    acl_pkg::spi_byte_t tx_reg;
    acl_pkg::spi_byte_t rx_reg;

    assign mosi    = tx_reg[acl_pkg::BYTE_W-1];     // MSB first
    assign rx_byte = rx_reg;

    always_ff @(posedge iclk or negedge rst_n) begin
        if (!rst_n) begin
            tx_reg <= '0;
        end else if (tx_req.start) begin
            tx_reg <= tx_req.data;
        end else if (shift_pulse) begin
            tx_reg <= {tx_reg[acl_pkg::BYTE_W-2:0], 1'b0};  // Moves while sclk falls
        end
    end

    always_ff @(posedge iclk) begin
        if (sample_pulse) begin
            rx_reg <= {rx_reg[acl_pkg::BYTE_W-2:0], miso};  // Sampled on the sclk rise
        end
    end

    a_no_load_during_shift: assert property (@(posedge iclk) disable iff (!rst_n)
        !(tx_req.start && shift_pulse))
        else $error("start collides with a shift");

endmodule

// ==== tb_acl_spi_top.sv ====
module tb_acl_spi_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED = 32'h4f3e_2218;
    localparam int NUM_SAMPLES   = 3;
    localparam int MARGIN        = 16000;
    localparam int CYCLE_LIMIT   = acl_pkg::POWER_UP_CYCLES + acl_pkg::MEAS_WAIT_CYCLES +
                                   NUM_SAMPLES * acl_pkg::READ_GAP_CYCLES + MARGIN;

    logic                 iclk;
    logic                 rst_n;
    logic                 miso;
    logic                 sclk;
    logic                 mosi;
    logic                 cs_n;
    acl_pkg::acl_sample_t acl_data;
    logic                 sample_valid;
    acl_pkg::acl_sample_t exp_sample;
    int                   frames;
    int                   model_errors;
    int                   errors;
    int                   samples;
    int                   cycles;
    logic                 timed_out;
    int unsigned          seed;

    acl_spi_top UUT (
        .iclk         (iclk),
        .rst_n        (rst_n),
        .miso         (miso),
        .sclk         (sclk),
        .mosi         (mosi),
        .cs_n         (cs_n),
        .acl_data     (acl_data),
        .sample_valid (sample_valid)
    );

    acl_sensor_model u_sensor (
        .iclk       (iclk),
        .rst_n      (rst_n),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_n       (cs_n),
        .miso       (miso),
        .exp_sample (exp_sample),
        .frames     (frames),
        .errors     (model_errors)
    );

    initial begin
        iclk = 1'b0;
        forever #20 iclk = ~iclk;                         // 40 ns period
    end

    always @(posedge iclk) begin
        cycles <= cycles + 1;
        if (rst_n && sample_valid) begin
            samples <= samples + 1;
        end
    end

    a_reset_state: assert property (@(posedge iclk)
        $rose(rst_n) |-> (cs_n && !sclk && !mosi && !sample_valid && acl_data == '0))
        else begin
            errors++;
            $display("ERR %0t: outputs not in reset state after reset", $time);
        end

    a_sample_value: assert property (@(posedge iclk) disable iff (!rst_n)
        sample_valid |-> acl_data == exp_sample)
        else begin
            errors++;
            $display("ERR %0t: acl_data %h, expected %h", $time,
                     $sampled(acl_data), $sampled(exp_sample));
        end

    a_valid_one_cycle: assert property (@(posedge iclk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else begin
            errors++;
            $display("ERR %0t: sample_valid longer than one cycle", $time);
        end

    initial begin
        seed = SEED;
        void'($urandom(seed));
        errors    = 0;
        samples   = 0;
        cycles    = 0;
        timed_out = 1'b0;
        rst_n     = 1'b0;
        repeat (2) @(posedge iclk);
        rst_n <= 1'b1;
        while (samples < NUM_SAMPLES && cycles < CYCLE_LIMIT) begin
            @(posedge iclk);
        end
        if (samples < NUM_SAMPLES) begin
            timed_out = 1'b1;
            $display("Run stopped at the cycle limit of %0d with only %0d of %0d samples",
                     CYCLE_LIMIT, samples, NUM_SAMPLES);
        end
        repeat (4) @(posedge iclk);                       // Let pending checks settle
        $display("Errors: %0d testbench, %0d sensor model; samples %0d, frames %0d",
                 errors, model_errors, samples, frames);
        if (!timed_out && errors == 0 && model_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
